// ==== hw/bp_settings.svh ====
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// Instruction address width
`define BP_ADDR_WIDTH 32

// Direct-mapped BTB geometry
`define BP_BTB_ENTRIES 8
`define BP_BTB_INDEX_BITS 3

// Fully associative correction buffer depth
`define BP_BCB_ENTRIES 8

// Byte step between sequential instructions
`define BP_INSTR_BYTES 4

// First fetch address out of reset
`define BP_RESET_PC 32'h0000_1000

`endif

// ==== hw/bp_pkg.sv ====
`include "bp_settings.svh"

package bp_pkg;

    // Byte offset bits below the BTB index
    localparam int unsigned OFFSET_BITS = $clog2(`BP_INSTR_BYTES);

    typedef logic [`BP_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`BP_BTB_INDEX_BITS-1:0] btb_index_t;
    typedef logic [`BP_ADDR_WIDTH-`BP_BTB_INDEX_BITS-OFFSET_BITS-1:0] btb_tag_t;
    typedef logic [1:0] counter_t;     // Upper bit set means predict taken
    typedef logic [$clog2(`BP_BCB_ENTRIES)-1:0] bcb_ptr_t;

    // BTB lookup result for the current fetch address
    typedef struct packed {
        logic  hit;
        logic  taken;
        addr_t target;
    } fetch_pred_t;

    // Branch outcome coming back from execute
    typedef struct packed {
        logic  valid;
        logic  branch;
        addr_t pc;
        addr_t target;
        logic  taken;
    } resolve_t;

endpackage

// ==== hw/branch_target_buffer.sv ====
`timescale 1ns/1ns
`include "bp_settings.svh"

module branch_target_buffer (
    input  logic                clk,
    input  logic                reset,
    input  bp_pkg::addr_t       fetch_pc,
    input  bp_pkg::resolve_t    resolve,
    output bp_pkg::fetch_pred_t pred
);

    localparam bp_pkg::counter_t WEAK_NOT_TAKEN = 2'b01;
    localparam bp_pkg::counter_t WEAK_TAKEN     = 2'b10;
    localparam bp_pkg::counter_t STRONG_TAKEN   = 2'b11;
    localparam bp_pkg::counter_t STRONG_NOT     = 2'b00;
    localparam int unsigned      TAG_BITS       = $bits(bp_pkg::btb_tag_t);

    logic [`BP_BTB_ENTRIES-1:0] valid;
    bp_pkg::btb_tag_t           tags     [`BP_BTB_ENTRIES];
    bp_pkg::addr_t              targets  [`BP_BTB_ENTRIES];
    bp_pkg::counter_t           counters [`BP_BTB_ENTRIES];

    bp_pkg::btb_index_t fetch_idx;
    bp_pkg::btb_tag_t   fetch_tag;
    bp_pkg::btb_index_t upd_idx;
    bp_pkg::btb_tag_t   upd_tag;
    logic               upd_en;
    logic               upd_hit;
    bp_pkg::counter_t   cnt_next;

    // Split fetch and resolve addresses into set index and tag
    assign fetch_idx = fetch_pc[bp_pkg::OFFSET_BITS +: `BP_BTB_INDEX_BITS];
    assign fetch_tag = fetch_pc[`BP_ADDR_WIDTH-1 -: TAG_BITS];
    assign upd_idx   = resolve.pc[bp_pkg::OFFSET_BITS +: `BP_BTB_INDEX_BITS];
    assign upd_tag   = resolve.pc[`BP_ADDR_WIDTH-1 -: TAG_BITS];

    // Fetch-time lookup
    assign pred.hit    = valid[fetch_idx] && (tags[fetch_idx] == fetch_tag);
    assign pred.taken  = counters[fetch_idx][1];
    assign pred.target = targets[fetch_idx];

    assign upd_en  = resolve.valid && resolve.branch;
    assign upd_hit = valid[upd_idx] && (tags[upd_idx] == upd_tag);

    // Next counter value for the resolved set
    always_comb begin
        if (!upd_hit) begin
            cnt_next = resolve.taken ? WEAK_TAKEN : WEAK_NOT_TAKEN;   // Fresh allocation
        end else if (resolve.taken) begin
            if (counters[upd_idx] == STRONG_TAKEN) begin
                cnt_next = STRONG_TAKEN;
            end else begin
                cnt_next = counters[upd_idx] + 2'd1;
            end
        end else begin
            if (counters[upd_idx] == STRONG_NOT) begin
                cnt_next = STRONG_NOT;
            end else begin
                cnt_next = counters[upd_idx] - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (upd_en) begin
            valid[upd_idx] <= 1'b1;
        end
    end

    // Tag, target and counter written on every resolved branch
    always_ff @(posedge clk) begin
        if (upd_en) begin
            tags[upd_idx]     <= upd_tag;
            targets[upd_idx]  <= resolve.target;
            counters[upd_idx] <= cnt_next;
        end
    end

endmodule

// ==== hw/branch_correction_buffer.sv ====
`timescale 1ns/1ns
`include "bp_settings.svh"

module branch_correction_buffer (
    input  logic                clk,
    input  logic                reset,
    input  bp_pkg::addr_t       fetch_pc,
    input  bp_pkg::fetch_pred_t pred,
    input  bp_pkg::resolve_t    resolve,
    output logic                mispredict,
    output bp_pkg::addr_t       redirect_pc
);

    logic [`BP_BCB_ENTRIES-1:0] valid;
    logic [`BP_BCB_ENTRIES-1:0] taken_q;
    bp_pkg::addr_t              pcs      [`BP_BCB_ENTRIES];
    bp_pkg::addr_t              reverses [`BP_BCB_ENTRIES];
    bp_pkg::bcb_ptr_t           rr_ptr;     // Round-robin victim when full

    logic             wr_match;
    bp_pkg::bcb_ptr_t wr_idx;
    logic             free_found;
    bp_pkg::bcb_ptr_t free_idx;
    logic             chk_match;
    bp_pkg::bcb_ptr_t chk_idx;
    bp_pkg::bcb_ptr_t alloc_idx;
    bp_pkg::bcb_ptr_t slot;
    bp_pkg::addr_t    reverse_new;

    // Searches run from the top down so the lowest slot wins
    always_comb begin
        wr_match   = 1'b0;
        wr_idx     = '0;
        free_found = 1'b0;
        free_idx   = '0;
        chk_match  = 1'b0;
        chk_idx    = '0;
        for (int i = `BP_BCB_ENTRIES - 1; i >= 0; i--) begin
            if (valid[i] && (pcs[i] == fetch_pc)) begin
                wr_match = 1'b1;
                wr_idx   = bp_pkg::bcb_ptr_t'(i);
            end
            if (!valid[i]) begin
                free_found = 1'b1;
                free_idx   = bp_pkg::bcb_ptr_t'(i);
            end
            if (valid[i] && (pcs[i] == resolve.pc)) begin
                chk_match = 1'b1;
                chk_idx   = bp_pkg::bcb_ptr_t'(i);
            end
        end
    end

    assign alloc_idx = free_found ? free_idx : rr_ptr;
    assign slot      = wr_match ? wr_idx : alloc_idx;

    // Address to fall back to if the prediction turns out wrong
    assign reverse_new = pred.taken ? fetch_pc + bp_pkg::addr_t'(`BP_INSTR_BYTES)
                                    : pred.target;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid  <= '0;
            rr_ptr <= '0;
        end else if (pred.hit) begin
            valid[slot] <= 1'b1;
            if (!wr_match) begin
                rr_ptr <= rr_ptr + bp_pkg::bcb_ptr_t'(1);   // Wraps at the buffer depth
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pred.hit) begin
            pcs[slot]      <= fetch_pc;
            taken_q[slot]  <= pred.taken;
            reverses[slot] <= reverse_new;
        end
    end

    // Execute-side check against the recorded direction
    assign mispredict = resolve.valid && resolve.branch && chk_match
                        && (taken_q[chk_idx] != resolve.taken);
    assign redirect_pc = chk_match ? reverses[chk_idx] : '0;

endmodule

// ==== hw/next_pc_select.sv ====
`timescale 1ns/1ns
`include "bp_settings.svh"

module next_pc_select (
    input  logic                clk,
    input  logic                reset,
    input  bp_pkg::fetch_pred_t pred,
    input  logic                mispredict,
    input  bp_pkg::addr_t       redirect_pc,
    output bp_pkg::addr_t       fetch_pc
);

    bp_pkg::addr_t next_pc;
    bp_pkg::addr_t seq_pc;

    assign seq_pc = fetch_pc + bp_pkg::addr_t'(`BP_INSTR_BYTES);

    // Redirect beats the predicted target, which beats fall-through
    always_comb begin
        if (mispredict) begin
            next_pc = redirect_pc;
        end else if (pred.hit && pred.taken) begin
            next_pc = pred.target;
        end else begin
            next_pc = seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc <= `BP_RESET_PC;
        end else begin
            fetch_pc <= next_pc;
        end
    end

endmodule

// ==== hw/branch_predict_unit.sv ====
`timescale 1ns/1ns

module branch_predict_unit (
    input  logic             clk,
    input  logic             reset,
    input  bp_pkg::resolve_t resolve,
    output bp_pkg::addr_t    fetch_pc,
    output logic             mispredict,
    output bp_pkg::addr_t    redirect_pc
);

    bp_pkg::fetch_pred_t pred;   // BTB result for the current fetch

    branch_target_buffer u_branch_target_buffer (
        .clk      (clk),
        .reset    (reset),
        .fetch_pc (fetch_pc),
        .resolve  (resolve),
        .pred     (pred)
    );

    // Records reverse addresses at fetch and checks them at execute
    branch_correction_buffer u_branch_correction_buffer (
        .clk         (clk),
        .reset       (reset),
        .fetch_pc    (fetch_pc),
        .pred        (pred),
        .resolve     (resolve),
        .mispredict  (mispredict),
        .redirect_pc (redirect_pc)
    );

    next_pc_select u_next_pc_select (
        .clk         (clk),
        .reset       (reset),
        .pred        (pred),
        .mispredict  (mispredict),
        .redirect_pc (redirect_pc),
        .fetch_pc    (fetch_pc)
    );

endmodule

// ==== verification/branch_predict_tb.sv ====
`timescale 1ns/1ns
`include "bp_settings.svh"

module branch_predict_tb;

    localparam int RANDOM_CYCLES   = 2000;
    localparam int DIRECTED_CYCLES = 300;    // Generous bound for tests 1 to 5
    localparam int WAIT_LIMIT      = 40;
    localparam bp_pkg::addr_t    EVICT_BASE = 32'h0000_1060;
    localparam bp_pkg::resolve_t IDLE       = '0;

    logic             clk;
    logic             reset;
    bp_pkg::resolve_t resolve;
    bp_pkg::addr_t    fetch_pc;
    logic             mispredict;
    bp_pkg::addr_t    redirect_pc;

    // Reference model of the BTB and correction buffer
    logic [`BP_BTB_ENTRIES-1:0] m_btb_valid;
    bp_pkg::btb_tag_t           m_btb_tag    [`BP_BTB_ENTRIES];
    bp_pkg::addr_t              m_btb_target [`BP_BTB_ENTRIES];
    bp_pkg::counter_t           m_btb_cnt    [`BP_BTB_ENTRIES];
    logic [`BP_BCB_ENTRIES-1:0] m_bcb_valid;
    bp_pkg::addr_t              m_bcb_pc     [`BP_BCB_ENTRIES];
    logic                       m_bcb_taken  [`BP_BCB_ENTRIES];
    bp_pkg::addr_t              m_bcb_rev    [`BP_BCB_ENTRIES];
    bp_pkg::bcb_ptr_t           m_rr;
    bp_pkg::addr_t              m_pc;
    bp_pkg::resolve_t           cur_res;     // Resolve seen by the DUT this cycle

    logic          m_hit;
    logic          m_taken;
    bp_pkg::addr_t m_target;
    logic          m_mis;
    bp_pkg::addr_t m_redir;
    bp_pkg::addr_t pool [16];

    int seed = 98472;
    int errors;
    int test_errors;
    int pass_count;
    int fail_count;

    branch_predict_unit u_branch_predict_unit (
        .clk         (clk),
        .reset       (reset),
        .resolve     (resolve),
        .fetch_pc    (fetch_pc),
        .mispredict  (mispredict),
        .redirect_pc (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #((RANDOM_CYCLES + DIRECTED_CYCLES + 100) * 20);
        $display("timeout: the tests did not finish within their cycle budget");
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s expected %h actual %h", $time, name,
                     expected, actual);
            errors++;
        end
    endtask

    function automatic bp_pkg::resolve_t branch_resolve(input bp_pkg::addr_t pc,
                                                        input bp_pkg::addr_t target,
                                                        input logic taken);
        bp_pkg::resolve_t res;
        res.valid  = 1'b1;
        res.branch = 1'b1;
        res.pc     = pc;
        res.target = target;
        res.taken  = taken;
        return res;
    endfunction

    // Expected lookup, mispredict and redirect for the current model state
    task automatic model_outputs();
        bp_pkg::btb_index_t idx;
        logic               found;
        idx      = m_pc[4:2];
        m_hit    = m_btb_valid[idx] && (m_btb_tag[idx] == m_pc[31:5]);
        m_taken  = m_btb_cnt[idx][1];
        m_target = m_btb_target[idx];
        found    = 1'b0;
        m_mis    = 1'b0;
        m_redir  = '0;
        for (int i = 0; i < `BP_BCB_ENTRIES; i++) begin
            if (!found && m_bcb_valid[i] && (m_bcb_pc[i] == cur_res.pc)) begin
                found   = 1'b1;
                m_redir = m_bcb_rev[i];
                m_mis   = cur_res.valid && cur_res.branch && (m_bcb_taken[i] != cur_res.taken);
            end
        end
    endtask

    // Model of one rising edge
    task automatic advance_model();
        bp_pkg::btb_index_t idx;
        bp_pkg::addr_t      next_pc;
        int                 slot;
        model_outputs();
        if (m_mis) begin
            next_pc = m_redir;
        end else if (m_hit && m_taken) begin
            next_pc = m_target;
        end else begin
            next_pc = m_pc + 32'(`BP_INSTR_BYTES);
        end
        if (m_hit) begin
            slot = -1;
            for (int i = 0; i < `BP_BCB_ENTRIES; i++) begin
                if (slot < 0 && m_bcb_valid[i] && m_bcb_pc[i] == m_pc) slot = i;
            end
            if (slot < 0) begin
                for (int i = 0; i < `BP_BCB_ENTRIES; i++) begin
                    if (slot < 0 && !m_bcb_valid[i]) slot = i;
                end
                if (slot < 0) slot = int'(m_rr);   // Evict round-robin when full
                m_rr = m_rr + 3'd1;
            end
            m_bcb_valid[slot] = 1'b1;
            m_bcb_pc[slot]    = m_pc;
            m_bcb_taken[slot] = m_taken;
            m_bcb_rev[slot]   = m_taken ? m_pc + 32'(`BP_INSTR_BYTES) : m_target;
        end
        if (cur_res.valid && cur_res.branch) begin
            idx = cur_res.pc[4:2];
            if (m_btb_valid[idx] && (m_btb_tag[idx] == cur_res.pc[31:5])) begin
                if (cur_res.taken && m_btb_cnt[idx] != 2'b11) begin
                    m_btb_cnt[idx] = m_btb_cnt[idx] + 2'd1;
                end else if (!cur_res.taken && m_btb_cnt[idx] != 2'b00) begin
                    m_btb_cnt[idx] = m_btb_cnt[idx] - 2'd1;
                end
            end else begin
                m_btb_valid[idx] = 1'b1;
                m_btb_tag[idx]   = cur_res.pc[31:5];
                m_btb_cnt[idx]   = cur_res.taken ? 2'b10 : 2'b01;
            end
            m_btb_target[idx] = cur_res.target;
        end
        m_pc = next_pc;
    endtask

    // Ends at the falling edge with the DUT back in its reset state
    task automatic do_reset();
        @(posedge clk);
        reset   <= 1'b1;
        resolve <= IDLE;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        m_btb_valid = '0;
        m_bcb_valid = '0;
        m_rr        = '0;
        m_pc        = `BP_RESET_PC;
        cur_res     = IDLE;
    endtask

    // One clock with res driven, outputs checked at the falling edge
    task automatic run_cycle(input bp_pkg::resolve_t res);
        advance_model();
        @(posedge clk);
        resolve <= res;
        cur_res = res;
        @(negedge clk);
        model_outputs();
        check_value("fetch_pc", m_pc, fetch_pc);
        check_value("mispredict", 32'(m_mis), 32'(mispredict));
        check_value("redirect_pc", m_redir, redirect_pc);
    endtask

    task automatic run_to(input bp_pkg::addr_t addr);
        int n;
        n = 0;
        while (m_pc != addr && n < WAIT_LIMIT) begin
            run_cycle(IDLE);
            n++;
        end
        if (m_pc != addr) begin
            $display("fetch never reached %h within %0d cycles", addr, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        bp_pkg::addr_t    a;
        bp_pkg::addr_t    t;
        bp_pkg::resolve_t res;
        logic [31:0]      r;
        reset   = 1'b1;
        resolve = IDLE;
        errors  = 0;
        do_reset();
        test_errors = 0;
        check_value("fetch_pc", `BP_RESET_PC, fetch_pc);
        for (int i = 1; i <= 10; i++) begin
            run_cycle(IDLE);
            check_value("fetch_pc", `BP_RESET_PC + 32'(4 * i), fetch_pc);
        end
        end_test("reset_and_sequential");

        a = m_pc + 32'h20;
        t = a + 32'h200;
        run_cycle(branch_resolve(a, t, 1'b1));
        run_to(a);
        run_cycle(IDLE);
        check_value("fetch_pc", t, fetch_pc);
        a = m_pc + 32'h40;                      // Trained down before it is fetched
        run_cycle(branch_resolve(a, a + 32'h300, 1'b1));
        run_cycle(branch_resolve(a, a + 32'h300, 1'b0));
        run_cycle(branch_resolve(a, a + 32'h300, 1'b0));
        run_to(a);
        run_cycle(IDLE);
        check_value("fetch_pc", a + 32'd4, fetch_pc);
        end_test("btb_training");

        a = m_pc + 32'h20;
        run_cycle(branch_resolve(a, a + 32'h180, 1'b1));
        run_to(a);
        run_cycle(branch_resolve(a, a + 32'h180, 1'b0));
        check_value("mispredict", 32'd1, 32'(mispredict));
        check_value("redirect_pc", a + 32'd4, redirect_pc);
        run_cycle(IDLE);
        check_value("fetch_pc", a + 32'd4, fetch_pc);
        end_test("mispredict_redirect");

        a = m_pc + 32'h20;
        t = a + 32'h100;
        run_cycle(branch_resolve(a, t, 1'b1));
        run_to(a);
        run_cycle(branch_resolve(a, t, 1'b1));      // Agrees with the prediction
        check_value("mispredict", 32'd0, 32'(mispredict));
        res        = branch_resolve(a, t, 1'b0);
        res.branch = 1'b0;
        run_cycle(res);
        check_value("mispredict", 32'd0, 32'(mispredict));
        run_cycle(branch_resolve(32'h0008_0000, t, 1'b0));
        check_value("mispredict", 32'd0, 32'(mispredict));
        end_test("no_false_mispredict");

        do_reset();
        run_cycle(branch_resolve(a, t, 1'b0));      // Entry for a was recorded as taken
        check_value("mispredict", 32'd0, 32'(mispredict));
        for (int k = 0; k < 8; k++) begin
            a = EVICT_BASE + 32'(4 * k);
            run_cycle(branch_resolve(a, a + 32'h400, 1'b0));
        end
        run_to(EVICT_BASE);
        for (int k = 0; k < 8; k++) begin
            if (k == 2 || k == 3) begin
                a = EVICT_BASE + 32'(32 + 4 * (k - 2));   // Same sets as the first two
                run_cycle(branch_resolve(a, a + 32'h400, 1'b0));
            end else begin
                run_cycle(IDLE);
            end
        end
        run_cycle(IDLE);
        run_cycle(branch_resolve(EVICT_BASE, EVICT_BASE + 32'h400, 1'b1));
        check_value("mispredict", 32'd0, 32'(mispredict));
        run_cycle(branch_resolve(EVICT_BASE + 32'd4, EVICT_BASE + 32'h404, 1'b1));
        check_value("mispredict", 32'd0, 32'(mispredict));
        run_cycle(branch_resolve(EVICT_BASE + 32'd8, EVICT_BASE + 32'h408, 1'b1));
        check_value("mispredict", 32'd1, 32'(mispredict));
        check_value("redirect_pc", EVICT_BASE + 32'h408, redirect_pc);
        end_test("round_robin_eviction");

        do_reset();
        for (int i = 0; i < 16; i++) begin
            pool[i] = `BP_RESET_PC + 32'(i * 20);
        end
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            r          = $random(seed);
            res.valid  = (r[2:0] != 3'd0);
            res.branch = (r[4:3] != 2'd0);
            res.pc     = (r[6:5] == 2'd0) ? m_pc : pool[r[10:7]];
            res.target = pool[r[14:11]];
            res.taken  = (r[16:15] != 2'd0);
            run_cycle(res);
        end
        end_test("random_run");

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== branch_predict.f ====
+incdir+hw
hw/bp_pkg.sv
hw/branch_target_buffer.sv
hw/branch_correction_buffer.sv
hw/next_pc_select.sv
hw/branch_predict_unit.sv
verification/branch_predict_tb.sv

// ==== Makefile ====
# Verilator build and run of the branch prediction testbench

VERILATOR ?= verilator
TOP       ?= branch_predict_tb
FILELIST  ?= branch_predict.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= STATUS: PASS

SOURCES := $(wildcard hw/*.sv hw/*.svh verification/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
